// File: Bender.yml
package:
  name: crbParser

sources:
  - include_dirs:
      - src
    files:
      - src/crbPkg.sv
      - src/byteFetcher.sv
      - src/commandLookup.sv
      - src/commandDecoder.sv
      - src/execSequencer.sv
      - src/responseBuilder.sv
      - src/crbTop.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/crbChecker.sv
      - test/crbTb.sv

// File: crbParser.f
+incdir+src
src/crbPkg.sv
src/byteFetcher.sv
src/commandLookup.sv
src/commandDecoder.sv
src/execSequencer.sv
src/responseBuilder.sv
src/crbTop.sv
test/crbChecker.sv
test/crbTb.sv

// File: src/byteFetcher.sv
`timescale 1ns/1ps

module byteFetcher
(
	input logic clock,
	input logic reset_n,
	input logic fetchStart,
	input crbPkg::offsetT fetchCount,
	input logic fetchRestart,
	input logic [7:0] cmdByte,
	output logic cmdRead,
	output crbPkg::offsetT cmdAddr,
	output logic [7:0] fetchByte,
	output logic fetchValid,
	output crbPkg::offsetT fetchIndex,
	output logic fetchDone,
	output crbPkg::offsetT cursor
);

	typedef enum logic [1:0] {fetchIdle, fetchRead, fetchWait, fetchFinish} fetchStateT;

	fetchStateT state;
	crbPkg::offsetT remain;
	crbPkg::offsetT relIndex;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= fetchIdle;
			cursor <= '0;
			remain <= '0;
			relIndex <= '0;
			fetchByte <= '0;
			fetchValid <= 1'b0;
			fetchIndex <= '0;
			fetchDone <= 1'b0;
		end
		else
		begin
			fetchValid <= 1'b0;
			fetchDone <= 1'b0;
			case (state)
				fetchIdle:
					if (fetchStart)
					begin
						relIndex <= '0;
						remain <= fetchCount;
						// empty request finishes right away
						if (fetchCount == '0)
							fetchDone <= 1'b1;
						else
							state <= fetchRead;
					end
				fetchRead:
					state <= fetchWait;
				fetchWait:
				begin
					// host holds the byte for this whole cycle
					fetchByte <= cmdByte;
					fetchValid <= 1'b1;
					fetchIndex <= relIndex;
					relIndex <= relIndex + 1'b1;
					remain <= remain - 1'b1;
					cursor <= cursor + 1'b1;
					state <= (remain == 1) ? fetchFinish : fetchRead;
				end
				fetchFinish:
				begin
					fetchDone <= 1'b1;
					state <= fetchIdle;
				end
				default:
					state <= fetchIdle;
			endcase
			if (fetchRestart)
				cursor <= '0;
		end
	end

	assign cmdRead = (state == fetchRead);
	assign cmdAddr = cursor;

endmodule

// File: src/commandDecoder.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module commandDecoder
(
	input logic clock,
	input logic reset_n,
	input logic cmdSend,
	input logic [31:0] cmdSize,
	input logic [7:0] fetchByte,
	input logic fetchValid,
	input crbPkg::offsetT fetchIndex,
	input logic fetchDone,
	input crbPkg::offsetT cursor,
	input logic execFinished,
	output logic fetchStart,
	output crbPkg::offsetT fetchCount,
	output logic fetchRestart,
	output logic execRequest,
	output logic commandKnown,
	output crbPkg::tagT commandTag,
	output crbPkg::ccT commandCode,
	output logic [31:0] authSize,
	output crbPkg::handleT handle0, handle1, handle2,
	output crbPkg::handleT sessionHandle0, sessionHandle1, sessionHandle2,
	output crbPkg::sizeT nonceSize0, nonceSize1, nonceSize2,
	output crbPkg::offsetT nonceAddr0, nonceAddr1, nonceAddr2,
	output logic [7:0] sessionAttributes0, sessionAttributes1, sessionAttributes2,
	output crbPkg::sizeT hmacSize0, hmacSize1, hmacSize2,
	output crbPkg::offsetT hmacAddr0, hmacAddr1, hmacAddr2,
	output logic sessionValid0, sessionValid1, sessionValid2
);

	localparam crbPkg::offsetT headerBytes = `CRB_HEADER_LEN;
	localparam crbPkg::offsetT fieldBytes = 4;
	localparam crbPkg::offsetT sessionABytes = 6;
	localparam crbPkg::offsetT sessionBBytes = 3;

	crbPkg::parseStateT state;
	crbPkg::countT handleCount;
	crbPkg::countT sessionCount;
	crbPkg::countT slot;
	logic [31:0] sizeReg;
	logic stepping;
	logic abandon;
	crbPkg::handleT [`CRB_MAX_SLOTS-1:0] handles;
	crbPkg::handleT [`CRB_MAX_SLOTS-1:0] sessionHandles;
	crbPkg::sizeT [`CRB_MAX_SLOTS-1:0] nonceSizes;
	crbPkg::sizeT [`CRB_MAX_SLOTS-1:0] hmacSizes;
	crbPkg::offsetT [`CRB_MAX_SLOTS-1:0] nonceAddrs;
	crbPkg::offsetT [`CRB_MAX_SLOTS-1:0] hmacAddrs;
	logic [`CRB_MAX_SLOTS-1:0][7:0] attributes;
	logic [`CRB_MAX_SLOTS-1:0] validBits;

	commandLookup u_lookup
	(
		.commandCode(commandCode),
		.handleCount(handleCount),
		.sessionCount(sessionCount),
		.commandKnown(commandKnown)
	);

	// overrun is only judged once the header is in
	assign stepping = fetchDone || state == crbPkg::psHandleCheck ||
		state == crbPkg::psSessionCheck;
	assign abandon = stepping && (32'(cursor) > sizeReg) && state != crbPkg::psIdle &&
		state != crbPkg::psHeader && state != crbPkg::psExecWait;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= crbPkg::psIdle;
			slot <= '0;
			sizeReg <= '0;
			fetchStart <= 1'b0;
			fetchCount <= '0;
			fetchRestart <= 1'b0;
			execRequest <= 1'b0;
			commandTag <= '0;
			commandCode <= '0;
			authSize <= '0;
			handles <= '0;
			sessionHandles <= '0;
			nonceSizes <= '0;
			hmacSizes <= '0;
			nonceAddrs <= '0;
			hmacAddrs <= '0;
			attributes <= '0;
			validBits <= '0;
		end
		else
		begin
			fetchStart <= 1'b0;
			fetchRestart <= 1'b0;
			execRequest <= 1'b0;

			// fields arrive msb first, shift them in
			if (fetchValid)
				case (state)
					crbPkg::psHeader:
						if (fetchIndex < 2)
							commandTag <= {commandTag[7:0], fetchByte};
						else if (fetchIndex >= 6)
							commandCode <= {commandCode[23:0], fetchByte};
					crbPkg::psHandle:
						handles[slot] <= {handles[slot][23:0], fetchByte};
					crbPkg::psAuthSize:
						authSize <= {authSize[23:0], fetchByte};
					crbPkg::psSessionA:
						if (fetchIndex < 4)
							sessionHandles[slot] <= {sessionHandles[slot][23:0], fetchByte};
						else
							nonceSizes[slot] <= {nonceSizes[slot][7:0], fetchByte};
					crbPkg::psSessionB:
						if (fetchIndex == 0)
							attributes[slot] <= fetchByte;
						else
							hmacSizes[slot] <= {hmacSizes[slot][7:0], fetchByte};
					default:
						;
				endcase

			if (abandon)
			begin
				// no session marked valid after an overrun
				state <= crbPkg::psExecWait;
				execRequest <= 1'b1;
			end
			else
				case (state)
					crbPkg::psIdle:
						if (cmdSend)
						begin
							sizeReg <= cmdSize;
							fetchRestart <= 1'b1;
							fetchStart <= 1'b1;
							fetchCount <= headerBytes;
							commandTag <= '0;
							commandCode <= '0;
							authSize <= '0;
							handles <= '0;
							sessionHandles <= '0;
							nonceSizes <= '0;
							hmacSizes <= '0;
							nonceAddrs <= '0;
							hmacAddrs <= '0;
							attributes <= '0;
							validBits <= '0;
							state <= crbPkg::psHeader;
						end
					crbPkg::psHeader:
						if (fetchDone)
						begin
							slot <= '0;
							state <= crbPkg::psHandleCheck;
						end
					crbPkg::psHandleCheck:
						if (slot < handleCount)
						begin
							fetchStart <= 1'b1;
							fetchCount <= fieldBytes;
							state <= crbPkg::psHandle;
						end
						else if (sessionCount != '0)
						begin
							fetchStart <= 1'b1;
							fetchCount <= fieldBytes;
							state <= crbPkg::psAuthSize;
						end
						else
						begin
							state <= crbPkg::psExecWait;
							execRequest <= 1'b1;
						end
					crbPkg::psHandle:
						if (fetchDone)
						begin
							slot <= slot + 1'b1;
							state <= crbPkg::psHandleCheck;
						end
					crbPkg::psAuthSize:
						if (fetchDone)
						begin
							slot <= '0;
							state <= crbPkg::psSessionCheck;
						end
					crbPkg::psSessionCheck:
						if (slot < sessionCount)
						begin
							fetchStart <= 1'b1;
							fetchCount <= sessionABytes;
							state <= crbPkg::psSessionA;
						end
						else
						begin
							for (int i = 0; i < `CRB_MAX_SLOTS; i++)
								validBits[i] <= (i < sessionCount);
							state <= crbPkg::psExecWait;
							execRequest <= 1'b1;
						end
					crbPkg::psSessionA:
						if (fetchDone)
						begin
							// nonce is skipped, only its offset is kept
							nonceAddrs[slot] <= cursor;
							fetchStart <= 1'b1;
							fetchCount <= nonceSizes[slot][`CRB_ADDR_W-1:0];
							state <= crbPkg::psNonce;
						end
					crbPkg::psNonce:
						if (fetchDone)
						begin
							fetchStart <= 1'b1;
							fetchCount <= sessionBBytes;
							state <= crbPkg::psSessionB;
						end
					crbPkg::psSessionB:
						if (fetchDone)
						begin
							hmacAddrs[slot] <= cursor;
							fetchStart <= 1'b1;
							fetchCount <= hmacSizes[slot][`CRB_ADDR_W-1:0];
							state <= crbPkg::psHmac;
						end
					crbPkg::psHmac:
						if (fetchDone)
						begin
							slot <= slot + 1'b1;
							state <= crbPkg::psSessionCheck;
						end
					crbPkg::psExecWait:
						if (execFinished)
							state <= crbPkg::psIdle;
					default:
						state <= crbPkg::psIdle;
				endcase
		end
	end

	assign {handle2, handle1, handle0} = handles;
	assign {sessionHandle2, sessionHandle1, sessionHandle0} = sessionHandles;
	assign {nonceSize2, nonceSize1, nonceSize0} = nonceSizes;
	assign {nonceAddr2, nonceAddr1, nonceAddr0} = nonceAddrs;
	assign {sessionAttributes2, sessionAttributes1, sessionAttributes0} = attributes;
	assign {hmacSize2, hmacSize1, hmacSize0} = hmacSizes;
	assign {hmacAddr2, hmacAddr1, hmacAddr0} = hmacAddrs;
	assign {sessionValid2, sessionValid1, sessionValid0} = validBits;

endmodule

// File: src/commandLookup.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module commandLookup
(
	input crbPkg::ccT commandCode,
	output crbPkg::countT handleCount,
	output crbPkg::countT sessionCount,
	output logic commandKnown
);

	always_comb
	begin
		commandKnown = 1'b1;
		case (commandCode)
			`CRB_CC_STARTUP:
				{handleCount, sessionCount} = {2'd0, 2'd0};
			`CRB_CC_GET_RANDOM:
				{handleCount, sessionCount} = {2'd0, 2'd0};
			`CRB_CC_NV_READ_PUBLIC:
				{handleCount, sessionCount} = {2'd1, 2'd0};
			`CRB_CC_CLEAR:
				{handleCount, sessionCount} = {2'd1, 2'd1};
			`CRB_CC_NV_WRITE:
				{handleCount, sessionCount} = {2'd2, 2'd1};
			`CRB_CC_CERTIFY:
				{handleCount, sessionCount} = {2'd2, 2'd2};
			`CRB_CC_POLICY_NV:
				{handleCount, sessionCount} = {2'd3, 2'd1};
			`CRB_CC_NV_CERTIFY:
				{handleCount, sessionCount} = {2'd3, 2'd2};
			default:
			begin
				// unknown code, parsed as header only
				{handleCount, sessionCount} = '0;
				commandKnown = 1'b0;
			end
		endcase
	end

endmodule

// File: src/crbPkg.sv
`include "crb_defines.svh"

package crbPkg;

	typedef logic [`CRB_ADDR_W-1:0] offsetT;
	typedef logic [31:0] handleT;
	typedef logic [15:0] sizeT;
	typedef logic [15:0] tagT;
	typedef logic [31:0] ccT;
	typedef logic [$clog2(`CRB_MAX_SLOTS+1)-1:0] countT;

	// decoder steps, one fetch per field group
	typedef enum logic [3:0]
	{
		psIdle,
		psHeader,
		psHandleCheck,
		psHandle,
		psAuthSize,
		psSessionCheck,
		psSessionA,
		psNonce,
		psSessionB,
		psHmac,
		psExecWait
	} parseStateT;

endpackage

// File: src/crbTop.sv
`timescale 1ns/1ps

module crbTop
(
	input logic clock,
	input logic reset_n,
	input logic cmdSend,
	input logic [31:0] cmdSize,
	input logic [7:0] cmdByte,
	input logic execAck,
	input crbPkg::ccT responseCode,
	output logic cmdRead,
	output crbPkg::offsetT cmdAddr,
	output logic cmdDone,
	output logic execStart,
	output logic [7:0] rspByte,
	output crbPkg::offsetT rspAddr,
	output logic rspValid,
	output logic rspDone,
	output crbPkg::tagT commandTag,
	output crbPkg::ccT commandCode,
	output logic [31:0] authSize,
	output crbPkg::handleT handle0, handle1, handle2,
	output crbPkg::handleT sessionHandle0, sessionHandle1, sessionHandle2,
	output crbPkg::sizeT nonceSize0, nonceSize1, nonceSize2,
	output crbPkg::offsetT nonceAddr0, nonceAddr1, nonceAddr2,
	output logic [7:0] sessionAttributes0, sessionAttributes1, sessionAttributes2,
	output crbPkg::sizeT hmacSize0, hmacSize1, hmacSize2,
	output crbPkg::offsetT hmacAddr0, hmacAddr1, hmacAddr2,
	output logic sessionValid0, sessionValid1, sessionValid2
);

	logic fetchStart;
	logic fetchRestart;
	logic fetchValid;
	logic fetchDone;
	logic commandKnown;
	logic execFinished;
	logic [7:0] fetchByte;
	crbPkg::offsetT fetchCount;
	crbPkg::offsetT fetchIndex;
	crbPkg::offsetT cursor;
	crbPkg::ccT finalCode;

	byteFetcher u_fetcher
	(
		.clock(clock),
		.reset_n(reset_n),
		.fetchStart(fetchStart),
		.fetchCount(fetchCount),
		.fetchRestart(fetchRestart),
		.cmdByte(cmdByte),
		.cmdRead(cmdRead),
		.cmdAddr(cmdAddr),
		.fetchByte(fetchByte),
		.fetchValid(fetchValid),
		.fetchIndex(fetchIndex),
		.fetchDone(fetchDone),
		.cursor(cursor)
	);

	// end of parsing doubles as the host's command-done pulse
	commandDecoder u_decoder
	(
		.execRequest(cmdDone),
		.*
	);

	execSequencer u_exec
	(
		.clock(clock),
		.reset_n(reset_n),
		.execRequest(cmdDone),
		.commandKnown(commandKnown),
		.execAck(execAck),
		.responseCode(responseCode),
		.execStart(execStart),
		.finalCode(finalCode),
		.execFinished(execFinished)
	);

	responseBuilder u_response
	(
		.clock(clock),
		.reset_n(reset_n),
		.execFinished(execFinished),
		.finalCode(finalCode),
		.commandTag(commandTag),
		.rspByte(rspByte),
		.rspAddr(rspAddr),
		.rspValid(rspValid),
		.rspDone(rspDone)
	);

endmodule

// File: src/crb_defines.svh
`ifndef CRB_DEFINES_SVH
`define CRB_DEFINES_SVH

// command buffer geometry
`define CRB_ADDR_W 12
`define CRB_MAX_SLOTS 3
`define CRB_HEADER_LEN 10

// structure tags
`define CRB_ST_NO_SESSIONS 16'h8001
`define CRB_ST_SESSIONS 16'h8002

// response codes
`define CRB_RC_SUCCESS 32'h00000000
`define CRB_RC_COMMAND_CODE 32'h00000143

// supported command codes, handle/session counts in the lookup table
`define CRB_CC_STARTUP 32'h00000144
`define CRB_CC_GET_RANDOM 32'h0000017B
`define CRB_CC_NV_READ_PUBLIC 32'h00000169
`define CRB_CC_CLEAR 32'h00000126
`define CRB_CC_NV_WRITE 32'h00000137
`define CRB_CC_CERTIFY 32'h00000148
`define CRB_CC_POLICY_NV 32'h00000149
`define CRB_CC_NV_CERTIFY 32'h00000184

`endif

// File: src/execSequencer.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module execSequencer
(
	input logic clock,
	input logic reset_n,
	input logic execRequest,
	input logic commandKnown,
	input logic execAck,
	input crbPkg::ccT responseCode,
	output logic execStart,
	output crbPkg::ccT finalCode,
	output logic execFinished
);

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			execStart <= 1'b0;
			finalCode <= '0;
			execFinished <= 1'b0;
		end
		else
		begin
			execFinished <= 1'b0;
			if (execRequest)
				execStart <= 1'b1;
			else if (execStart && execAck)
			begin
				execStart <= 1'b0;
				execFinished <= 1'b1;
				// unknown commands never report the executor's code
				if (commandKnown)
					finalCode <= responseCode;
				else
					finalCode <= `CRB_RC_COMMAND_CODE;
			end
		end
	end

endmodule

// File: src/responseBuilder.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module responseBuilder
(
	input logic clock,
	input logic reset_n,
	input logic execFinished,
	input crbPkg::ccT finalCode,
	input crbPkg::tagT commandTag,
	output logic [7:0] rspByte,
	output crbPkg::offsetT rspAddr,
	output logic rspValid,
	output logic rspDone
);

	localparam crbPkg::offsetT lastAddr = `CRB_HEADER_LEN - 1;

	crbPkg::tagT rspTag;

	// errors always answer with the plain tag
	assign rspTag = (finalCode == `CRB_RC_SUCCESS) ? commandTag : `CRB_ST_NO_SESSIONS;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			rspAddr <= '0;
			rspValid <= 1'b0;
			rspDone <= 1'b0;
		end
		else
		begin
			rspDone <= 1'b0;
			if (execFinished)
			begin
				rspAddr <= '0;
				rspValid <= 1'b1;
			end
			else if (rspValid)
			begin
				if (rspAddr == lastAddr)
				begin
					rspValid <= 1'b0;
					rspDone <= 1'b1;
				end
				else
					rspAddr <= rspAddr + 1'b1;
			end
		end
	end

	always_comb
	begin
		case (rspAddr)
			0: rspByte = rspTag[15:8];
			1: rspByte = rspTag[7:0];
			5: rspByte = 8'(`CRB_HEADER_LEN);
			6: rspByte = finalCode[31:24];
			7: rspByte = finalCode[23:16];
			8: rspByte = finalCode[15:8];
			9: rspByte = finalCode[7:0];
			// upper size bytes are zero
			default: rspByte = 8'h00;
		endcase
	end

endmodule

// File: test/crbChecker.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module crbChecker
(
	input logic clock,
	input logic reset_n,
	input logic cmdSend,
	input logic [31:0] cmdSize,
	input logic execAck,
	input crbPkg::ccT responseCode,
	input logic [7:0] hostMem [0:(1 << `CRB_ADDR_W)-1],
	input logic cmdRead,
	input crbPkg::offsetT cmdAddr,
	input logic cmdDone,
	input logic execStart,
	input logic [7:0] rspByte,
	input crbPkg::offsetT rspAddr,
	input logic rspValid,
	input logic rspDone,
	input crbPkg::tagT commandTag,
	input crbPkg::ccT commandCode,
	input logic [31:0] authSize,
	input crbPkg::handleT handle0,
	input crbPkg::handleT handle1,
	input crbPkg::handleT handle2,
	input crbPkg::handleT sessionHandle0,
	input crbPkg::handleT sessionHandle1,
	input crbPkg::handleT sessionHandle2,
	input crbPkg::sizeT nonceSize0,
	input crbPkg::sizeT nonceSize1,
	input crbPkg::sizeT nonceSize2,
	input crbPkg::offsetT nonceAddr0,
	input crbPkg::offsetT nonceAddr1,
	input crbPkg::offsetT nonceAddr2,
	input logic [7:0] sessionAttributes0,
	input logic [7:0] sessionAttributes1,
	input logic [7:0] sessionAttributes2,
	input crbPkg::sizeT hmacSize0,
	input crbPkg::sizeT hmacSize1,
	input crbPkg::sizeT hmacSize2,
	input crbPkg::offsetT hmacAddr0,
	input crbPkg::offsetT hmacAddr1,
	input crbPkg::offsetT hmacAddr2,
	input logic sessionValid0,
	input logic sessionValid1,
	input logic sessionValid2,
	output int errorCount,
	output int checkedCount
);

	logic [15:0] expTag;
	logic [31:0] expCode;
	logic expKnown;
	logic [31:0] expAuth;
	logic [31:0] expHandle [0:2];
	logic [31:0] expSessionHandle [0:2];
	logic [15:0] expNonceSize [0:2];
	logic [11:0] expNonceAddr [0:2];
	logic [7:0] expAttributes [0:2];
	logic [15:0] expHmacSize [0:2];
	logic [11:0] expHmacAddr [0:2];
	logic expValid [0:2];
	logic [7:0] expRsp [0:9];
	logic pending;
	logic waitingRsp;
	logic prevStart;
	logic prevAck;
	logic prevRead;
	logic prevDone;
	logic prevReset;
	int sinceAck;
	int rspCount;
	int readCount;

	function automatic logic [31:0] readField(input int addr, input int len);
		logic [31:0] value;
		value = '0;
		for (int k = 0; k < len; k++)
			value = {value[23:0], hostMem[addr + k]};
		return value;
	endfunction

	// handle and session counts per command code
	function automatic void lookupCounts(input logic [31:0] code, output int hc,
		output int sc, output logic known);
		known = 1'b1;
		hc = 0;
		sc = 0;
		case (code)
			`CRB_CC_STARTUP, `CRB_CC_GET_RANDOM:
				;
			`CRB_CC_NV_READ_PUBLIC:
				hc = 1;
			`CRB_CC_CLEAR:
			begin
				hc = 1;
				sc = 1;
			end
			`CRB_CC_NV_WRITE:
			begin
				hc = 2;
				sc = 1;
			end
			`CRB_CC_CERTIFY:
			begin
				hc = 2;
				sc = 2;
			end
			`CRB_CC_POLICY_NV:
			begin
				hc = 3;
				sc = 1;
			end
			`CRB_CC_NV_CERTIFY:
			begin
				hc = 3;
				sc = 2;
			end
			default:
				known = 1'b0;
		endcase
	endfunction

	function automatic void clearExpected();
		expTag = '0;
		expCode = '0;
		expKnown = 1'b0;
		expAuth = '0;
		for (int i = 0; i < 3; i++)
		begin
			expHandle[i] = '0;
			expSessionHandle[i] = '0;
			expNonceSize[i] = '0;
			expNonceAddr[i] = '0;
			expAttributes[i] = '0;
			expHmacSize[i] = '0;
			expHmacAddr[i] = '0;
			expValid[i] = 1'b0;
		end
	endfunction

	// walks the command layout until the cursor passes the declared size
	function automatic void parseReference(input logic [31:0] declaredSize);
		int c;
		int hc;
		int sc;
		logic stop;
		clearExpected();
		expTag = readField(0, 2);
		expCode = readField(6, 4);
		lookupCounts(expCode, hc, sc, expKnown);
		c = `CRB_HEADER_LEN;
		stop = (c > declaredSize);
		for (int i = 0; i < hc && !stop; i++)
		begin
			expHandle[i] = readField(c, 4);
			c += 4;
			stop = (c > declaredSize);
		end
		if (sc != 0 && !stop)
		begin
			expAuth = readField(c, 4);
			c += 4;
			stop = (c > declaredSize);
		end
		for (int i = 0; i < sc && !stop; i++)
		begin
			expSessionHandle[i] = readField(c, 4);
			expNonceSize[i] = readField(c + 4, 2);
			c += 6;
			stop = (c > declaredSize);
			if (!stop)
			begin
				expNonceAddr[i] = c;
				c += expNonceSize[i];
				stop = (c > declaredSize);
			end
			if (!stop)
			begin
				expAttributes[i] = hostMem[c];
				expHmacSize[i] = readField(c + 1, 2);
				c += 3;
				stop = (c > declaredSize);
			end
			if (!stop)
			begin
				expHmacAddr[i] = c;
				c += expHmacSize[i];
				stop = (c > declaredSize);
			end
		end
		for (int i = 0; i < sc; i++)
			expValid[i] = !stop;
	endfunction

	function automatic void buildResponse(input logic [31:0] executorCode);
		logic [31:0] finalCode;
		logic [15:0] tag;
		finalCode = expKnown ? executorCode : `CRB_RC_COMMAND_CODE;
		tag = (finalCode == `CRB_RC_SUCCESS) ? expTag : `CRB_ST_NO_SESSIONS;
		expRsp[0] = tag[15:8];
		expRsp[1] = tag[7:0];
		expRsp[2] = 8'h00;
		expRsp[3] = 8'h00;
		expRsp[4] = 8'h00;
		expRsp[5] = 8'h0A;
		for (int i = 0; i < 4; i++)
			expRsp[6 + i] = finalCode[31 - 8 * i -: 8];
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
		begin
			$display("FAILED %s: got %0h, expected %0h", name, got, want);
			errorCount++;
		end
	endtask

	task automatic reportProblem(input string msg);
		$display("%s", msg);
		errorCount++;
	endtask

	task automatic compareCaptures();
		checkValue("commandTag", commandTag, expTag);
		checkValue("commandCode", commandCode, expCode);
		checkValue("authSize", authSize, expAuth);
		checkValue("handle0", handle0, expHandle[0]);
		checkValue("handle1", handle1, expHandle[1]);
		checkValue("handle2", handle2, expHandle[2]);
		checkValue("sessionHandle0", sessionHandle0, expSessionHandle[0]);
		checkValue("sessionHandle1", sessionHandle1, expSessionHandle[1]);
		checkValue("sessionHandle2", sessionHandle2, expSessionHandle[2]);
		checkValue("nonceSize0", nonceSize0, expNonceSize[0]);
		checkValue("nonceSize1", nonceSize1, expNonceSize[1]);
		checkValue("nonceSize2", nonceSize2, expNonceSize[2]);
		checkValue("nonceAddr0", nonceAddr0, expNonceAddr[0]);
		checkValue("nonceAddr1", nonceAddr1, expNonceAddr[1]);
		checkValue("nonceAddr2", nonceAddr2, expNonceAddr[2]);
		checkValue("sessionAttributes0", sessionAttributes0, expAttributes[0]);
		checkValue("sessionAttributes1", sessionAttributes1, expAttributes[1]);
		checkValue("sessionAttributes2", sessionAttributes2, expAttributes[2]);
		checkValue("hmacSize0", hmacSize0, expHmacSize[0]);
		checkValue("hmacSize1", hmacSize1, expHmacSize[1]);
		checkValue("hmacSize2", hmacSize2, expHmacSize[2]);
		checkValue("hmacAddr0", hmacAddr0, expHmacAddr[0]);
		checkValue("hmacAddr1", hmacAddr1, expHmacAddr[1]);
		checkValue("hmacAddr2", hmacAddr2, expHmacAddr[2]);
		checkValue("sessionValid0", sessionValid0, expValid[0]);
		checkValue("sessionValid1", sessionValid1, expValid[1]);
		checkValue("sessionValid2", sessionValid2, expValid[2]);
	endtask

	// values seen on the rising edge are the ones from the cycle before
	always @(posedge clock)
	begin
		if (!reset_n)
		begin
			errorCount = 0;
			checkedCount = 0;
			pending = 1'b0;
			waitingRsp = 1'b0;
			prevStart = 1'b0;
			prevAck = 1'b0;
			prevRead = 1'b0;
			prevDone = 1'b0;
			prevReset = 1'b0;
			sinceAck = 0;
			rspCount = 10;
			readCount = 0;
		end
		else
		begin
			if (!prevReset)
			begin
				// first edge after reset release
				clearExpected();
				checkValue("cmdRead", cmdRead, 0);
				checkValue("execStart", execStart, 0);
				checkValue("cmdDone", cmdDone, 0);
				checkValue("rspValid", rspValid, 0);
				checkValue("rspDone", rspDone, 0);
				compareCaptures();
				prevReset = 1'b1;
			end
			if (prevRead && cmdRead)
				reportProblem("cmdRead was high in two consecutive cycles");
			// bytes are read in order from the start of the command
			if (cmdRead)
			begin
				checkValue("cmdAddr", cmdAddr, readCount);
				readCount++;
			end
			if (prevDone && cmdDone)
				reportProblem("cmdDone was high in two consecutive cycles");
			if (prevStart && !prevAck && !execStart)
				reportProblem("execStart dropped before execAck came");
			if (prevStart && prevAck && execStart)
				reportProblem("execStart stayed high after execAck");
			if (execStart && !prevStart)
			begin
				if (!pending)
					reportProblem("execStart rose without a command being sent");
				if (!prevDone)
					reportProblem("execStart rose without cmdDone in the cycle before");
				compareCaptures();
				checkedCount++;
				pending = 1'b0;
			end
			if (waitingRsp)
			begin
				sinceAck++;
				if (rspValid)
				begin
					if (sinceAck != 2)
						reportProblem($sformatf("first response byte came %0d cycles after execAck",
							sinceAck));
					waitingRsp = 1'b0;
				end
			end
			if (execStart && execAck)
			begin
				buildResponse(responseCode);
				waitingRsp = 1'b1;
				sinceAck = 0;
				rspCount = 0;
			end
			if (rspValid)
			begin
				if (rspCount < 10)
				begin
					checkValue("rspAddr", rspAddr, rspCount);
					checkValue("rspByte", rspByte, expRsp[rspCount]);
				end
				else
					reportProblem("rspValid was high outside a response");
				rspCount++;
			end
			if (rspDone && rspCount != 10)
				reportProblem($sformatf("response had %0d bytes instead of 10", rspCount));
			if (cmdSend && !pending)
			begin
				parseReference(cmdSize);
				pending = 1'b1;
				readCount = 0;
			end
			prevRead = cmdRead;
			prevDone = cmdDone;
			prevStart = execStart;
			prevAck = execAck;
		end
	end

endmodule

// File: test/crbTb.sv
`timescale 1ns/1ps
`include "crb_defines.svh"

module crbTb;

	localparam int memDepth = 1 << `CRB_ADDR_W;
	localparam int fullSize = memDepth;
	localparam int waitLimit = 2000;

	logic clock = 1'b0;
	logic reset_n;
	logic cmdSend;
	logic [31:0] cmdSize;
	logic [7:0] cmdByte = 8'h00;
	logic execAck = 1'b0;
	crbPkg::ccT responseCode = '0;
	logic cmdRead;
	crbPkg::offsetT cmdAddr;
	logic cmdDone;
	logic execStart;
	logic [7:0] rspByte;
	crbPkg::offsetT rspAddr;
	logic rspValid;
	logic rspDone;
	crbPkg::tagT commandTag;
	crbPkg::ccT commandCode;
	logic [31:0] authSize;
	crbPkg::handleT handle0;
	crbPkg::handleT handle1;
	crbPkg::handleT handle2;
	crbPkg::handleT sessionHandle0;
	crbPkg::handleT sessionHandle1;
	crbPkg::handleT sessionHandle2;
	crbPkg::sizeT nonceSize0;
	crbPkg::sizeT nonceSize1;
	crbPkg::sizeT nonceSize2;
	crbPkg::offsetT nonceAddr0;
	crbPkg::offsetT nonceAddr1;
	crbPkg::offsetT nonceAddr2;
	logic [7:0] sessionAttributes0;
	logic [7:0] sessionAttributes1;
	logic [7:0] sessionAttributes2;
	crbPkg::sizeT hmacSize0;
	crbPkg::sizeT hmacSize1;
	crbPkg::sizeT hmacSize2;
	crbPkg::offsetT hmacAddr0;
	crbPkg::offsetT hmacAddr1;
	crbPkg::offsetT hmacAddr2;
	logic sessionValid0;
	logic sessionValid1;
	logic sessionValid2;

	logic [7:0] hostMem [0:memDepth-1];
	int errorCount;
	int checkedCount;
	int timeoutCount;
	int commandCount;
	int missingCount;
	logic abortRun;
	int plannedDelay;
	crbPkg::ccT plannedCode;
	int ackCount = 0;
	logic ackArmed = 1'b0;

	crbTop u_dut (.*);

	crbChecker u_checker (.*);

	always #20 clock = ~clock;

	// host buffer answers a read with the byte held through the next cycle
	always @(negedge clock)
		if (cmdRead)
			cmdByte = hostMem[cmdAddr];

	// executor acknowledges after the planned delay
	always @(negedge clock)
	begin
		if (execAck)
			execAck = 1'b0;
		else if (execStart)
		begin
			if (!ackArmed)
			begin
				ackCount = plannedDelay;
				ackArmed = 1'b1;
			end
			if (ackCount == 0)
			begin
				execAck = 1'b1;
				responseCode = plannedCode;
				ackArmed = 1'b0;
			end
			else
				ackCount--;
		end
	end

	task automatic fillBackground();
		for (int a = 0; a < memDepth; a++)
			hostMem[a] = 8'(a) ^ 8'(a >> 4);
	endtask

	// big-endian write at the running pointer
	task automatic putField(inout int wp, input logic [31:0] value, input int len);
		for (int k = len - 1; k >= 0; k--)
		begin
			hostMem[wp] = 8'(value >> (8 * k));
			wp++;
		end
	endtask

	task automatic buildCommand(input logic [15:0] tag, input logic [31:0] code,
		input int nHandles, input int nSessions, input int maxSize, output int declared);
		int wp;
		int authStart;
		int sizeAt;
		int nonceLen;
		int hmacLen;
		fillBackground();
		wp = 0;
		putField(wp, tag, 2);
		putField(wp, 0, 4);
		putField(wp, code, 4);
		for (int i = 0; i < nHandles; i++)
			putField(wp, 32'h80000000 | $urandom, 4);
		authStart = wp;
		if (nSessions > 0)
			wp += 4;
		for (int i = 0; i < nSessions; i++)
		begin
			putField(wp, 32'h02000000 | ($urandom % 32'h10000), 4);
			nonceLen = $urandom % 33;
			putField(wp, nonceLen, 2);
			for (int j = 0; j < nonceLen; j++)
				putField(wp, $urandom, 1);
			putField(wp, $urandom % 256, 1);
			hmacLen = $urandom % 33;
			putField(wp, hmacLen, 2);
			for (int j = 0; j < hmacLen; j++)
				putField(wp, $urandom, 1);
		end
		if (nSessions > 0)
		begin
			sizeAt = authStart;
			putField(sizeAt, wp - authStart - 4, 4);
		end
		declared = (wp > maxSize) ? maxSize : wp;
		sizeAt = 2;
		putField(sizeAt, declared, 4);
	endtask

	task automatic waitCmdDone();
		int cycles;
		cycles = 0;
		while (!cmdDone && cycles < waitLimit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!cmdDone)
		begin
			$display("timeout: parsing of command %0d never finished", commandCount);
			timeoutCount++;
			abortRun = 1'b1;
		end
	endtask

	task automatic waitRspDone();
		int cycles;
		cycles = 0;
		while (!rspDone && cycles < waitLimit)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!rspDone)
		begin
			$display("timeout: response of command %0d never finished", commandCount);
			timeoutCount++;
			abortRun = 1'b1;
		end
	endtask

	task automatic runCommand(input logic [15:0] tag, input logic [31:0] code,
		input int nHandles, input int nSessions, input int maxSize, input logic [31:0] rc);
		int declared;
		if (abortRun)
			return;
		buildCommand(tag, code, nHandles, nSessions, maxSize, declared);
		plannedCode = rc;
		plannedDelay = $urandom % 21;
		@(negedge clock);
		cmdSend = 1'b1;
		cmdSize = declared;
		@(negedge clock);
		cmdSend = 1'b0;
		commandCount++;
		waitCmdDone();
		if (!abortRun)
			waitRspDone();
	endtask

	initial
	begin
		void'($urandom(47948));
		reset_n = 1'b0;
		cmdSend = 1'b0;
		cmdSize = '0;
		timeoutCount = 0;
		commandCount = 0;
		missingCount = 0;
		abortRun = 1'b0;
		plannedDelay = 0;
		plannedCode = '0;
		fillBackground();
		repeat (10) @(negedge clock);
		reset_n = 1'b1;
		@(negedge clock);

		// header only
		runCommand(`CRB_ST_NO_SESSIONS, `CRB_CC_STARTUP, 0, 0, fullSize, `CRB_RC_SUCCESS);
		runCommand(`CRB_ST_NO_SESSIONS, `CRB_CC_GET_RANDOM, 0, 0, fullSize, `CRB_RC_SUCCESS);

		// handles and sessions with random nonce and hmac lengths
		for (int round = 0; round < 2; round++)
		begin
			runCommand(`CRB_ST_NO_SESSIONS, `CRB_CC_NV_READ_PUBLIC, 1, 0, fullSize, 0);
			runCommand(`CRB_ST_SESSIONS, `CRB_CC_CLEAR, 1, 1, fullSize, 0);
			runCommand(`CRB_ST_SESSIONS, `CRB_CC_NV_WRITE, 2, 1, fullSize, 0);
			runCommand(`CRB_ST_SESSIONS, `CRB_CC_CERTIFY, 2, 2, fullSize, 0);
			runCommand(`CRB_ST_SESSIONS, `CRB_CC_POLICY_NV, 3, 1, fullSize, 0);
			runCommand(`CRB_ST_SESSIONS, `CRB_CC_NV_CERTIFY, 3, 2, fullSize, 0);
		end

		// executor reports an error
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_CERTIFY, 2, 2, fullSize, 32'h0000098E);
		runCommand(`CRB_ST_NO_SESSIONS, `CRB_CC_NV_READ_PUBLIC, 1, 0, fullSize, 32'h0000018B);

		// codes outside the table
		runCommand(`CRB_ST_SESSIONS, 32'h00000199, 0, 0, fullSize, `CRB_RC_SUCCESS);
		runCommand(`CRB_ST_NO_SESSIONS, 32'h20000000, 0, 0, fullSize, 32'h00000101);

		// declared size cut short at several depths
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_NV_CERTIFY, 3, 2, 28, 0);
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_CLEAR, 1, 1, 24, 0);
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_POLICY_NV, 3, 1, 45, 0);
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_CERTIFY, 2, 2, 9, 0);
		runCommand(`CRB_ST_SESSIONS, `CRB_CC_NV_WRITE, 2, 1, 8, 32'h00000922);

		repeat (4) @(negedge clock);
		if (checkedCount != commandCount)
			missingCount = commandCount - checkedCount;
		$display("error counts: %0d check failures, %0d timeouts, %0d commands not checked",
			errorCount, timeoutCount, missingCount);
		if (errorCount == 0 && timeoutCount == 0 && missingCount == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule
